// File: Makefile
SRCS := $(wildcard common/*.sv common/*.svh cache/*.sv hw/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcache_tb: cache_sys.f $(SRCS)
	verilator --binary --timing -f cache_sys.f --top-module cache_tb -o Vcache_tb

run: obj_dir/Vcache_tb
	obj_dir/Vcache_tb | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: cache/cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  input  cache_types_pkg::cache_req_t   req,
  output logic                          ready,
  output logic                          resp_valid,
  output cache_types_pkg::cache_resp_t  resp,
  output logic [`CACHE_INDEX_BITS-1:0]  index,
  output logic                          tag_we,
  output cache_types_pkg::tag_entry_t   tag_wentry,
  output logic                          data_we,
  output cache_types_pkg::cache_line_t  data_wline,
  input  cache_types_pkg::tag_entry_t   tag_rentry,
  input  cache_types_pkg::cache_line_t  data_rline,
  output logic                          mem_valid,
  output mem_bus_pkg::mem_req_t         mem_req,
  input  logic                          mem_ready,
  input  logic                          mem_rvalid,
  input  cache_types_pkg::cache_line_t  mem_rline
);

  cache_types_pkg::cache_state_e state;
  cache_types_pkg::cache_state_e next_state;
  cache_types_pkg::cache_req_t   req_q;
  cache_types_pkg::cache_line_t  merged_line;

  logic [`CACHE_TAG_BITS-1:0]           req_tag;
  logic [$clog2(`CACHE_LINE_WORDS)-1:0] word_sel;
  logic                                 hit;
  logic                                 first_pass;

  // address split of the latched request
  assign req_tag  = req_q.addr[31 -: `CACHE_TAG_BITS];
  assign index    = req_q.addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
  assign word_sel = req_q.addr[`CACHE_OFFSET_BITS-1:2];

  assign hit   = tag_rentry.valid && (tag_rentry.tag == req_tag);
  assign ready = (state == cache_types_pkg::idle);

  // read word select and write word merge
  always_comb begin
    merged_line = data_rline;
    merged_line[word_sel*32 +: 32] = req_q.wdata;
  end

  assign resp.rdata = data_rline[word_sel*32 +: 32];
  assign resp.hit   = first_pass;

  always_comb begin
    next_state = state;
    resp_valid = 1'b0;
    tag_we = 1'b0;
    tag_wentry.tag = req_tag;
    tag_wentry.valid = 1'b1;
    tag_wentry.dirty = 1'b0;
    data_we = 1'b0;
    data_wline = merged_line;
    mem_valid = 1'b0;
    mem_req.op = mem_bus_pkg::mem_read;
    mem_req.line_addr = req_q.addr[31:`CACHE_OFFSET_BITS];
    mem_req.wdata = data_rline;
    case (state)
      cache_types_pkg::idle: begin
        if (req_valid) begin
          next_state = cache_types_pkg::compare;
        end
      end
      cache_types_pkg::compare: begin
        if (hit) begin
          resp_valid = 1'b1;
          next_state = cache_types_pkg::idle;
          // write hit marks the line dirty in the same cycle
          if (req_q.write) begin
            tag_we = 1'b1;
            tag_wentry.dirty = 1'b1;
            data_we = 1'b1;
          end
        end else if (mem_ready) begin
          mem_valid = 1'b1;
          if (tag_rentry.valid && tag_rentry.dirty) begin
            // evict the old line at {old tag, index}
            mem_req.op = mem_bus_pkg::mem_write;
            mem_req.line_addr = {tag_rentry.tag, index};
            next_state = cache_types_pkg::write_back;
          end else begin
            next_state = cache_types_pkg::fill;
          end
        end
      end
      cache_types_pkg::write_back: begin
        // read issued once the eviction is done
        if (mem_ready) begin
          mem_valid = 1'b1;
          next_state = cache_types_pkg::fill;
        end
      end
      cache_types_pkg::fill: begin
        if (mem_rvalid) begin
          tag_we = 1'b1;
          data_we = 1'b1;
          data_wline = mem_rline;
          next_state = cache_types_pkg::compare;
        end
      end
      default: begin
        next_state = cache_types_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_types_pkg::idle;
      first_pass <= 1'b0;
    end else begin
      state <= next_state;
      // hit flag only survives a lookup that hits at once
      if (req_valid && ready) begin
        first_pass <= 1'b1;
      end else if (state == cache_types_pkg::compare && !hit) begin
        first_pass <= 1'b0;
      end
    end
  end

  // request held for the whole access
  always_ff @(posedge clk) begin
    if (req_valid && ready) begin
      req_q <= req;
    end
  end

endmodule

// File: cache/cache_data_store.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_data_store (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`CACHE_INDEX_BITS-1:0]  index,
  input  logic                          we,
  input  cache_types_pkg::cache_line_t  wline,
  output cache_types_pkg::cache_line_t  rline
);

  cache_types_pkg::cache_line_t lines [`CACHE_NUM_SETS];

  // whole line written at once
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
        lines[i] <= '0;
      end
    end else if (we) begin
      lines[index] <= wline;
    end
  end

  // asynchronous read, the controller looks up in the same cycle
  assign rline = lines[index];

endmodule

// File: cache/cache_tag_store.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_tag_store (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`CACHE_INDEX_BITS-1:0]  index,
  input  logic                          we,
  input  cache_types_pkg::tag_entry_t   wentry,
  output cache_types_pkg::tag_entry_t   rentry
);

  logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_bits;
  logic [`CACHE_NUM_SETS-1:0] dirty_bits;

  // state bits, cleared on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (we) begin
      valid_bits[index] <= wentry.valid;
      dirty_bits[index] <= wentry.dirty;
    end
  end

  // tag payload only matters once valid is set
  always_ff @(posedge clk) begin
    if (we) begin
      tags[index] <= wentry.tag;
    end
  end

  // combinational read for the current index
  always_comb begin
    rentry.tag   = tags[index];
    rentry.valid = valid_bits[index];
    rentry.dirty = dirty_bits[index];
  end

endmodule

// File: cache_sys.f
+incdir+common
common/cache_types_pkg.sv
common/mem_bus_pkg.sv
cache/cache_tag_store.sv
cache/cache_data_store.sv
cache/cache_ctrl.sv
hw/line_memory.sv
hw/cache_top.sv
testbench/cache_tb.sv

// File: common/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_LINE_WORDS 4
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 4
`define CACHE_NUM_SETS 16
`define CACHE_TAG_BITS 24
`define CACHE_LINE_BITS 128

// backing memory, line addressed
`define MEM_LINE_ADDR_BITS 28
// 256 lines cover the lowest 4 KB
`define MEM_DEPTH 256
// cycles busy per line request
`define MEM_LATENCY 4

`endif

// File: common/cache_types_pkg.sv
`include "cache_defs.svh"

package cache_types_pkg;

  // one word request from the requester
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    logic [31:0] wdata;
  } cache_req_t;

  // hit reports the first lookup only
  typedef struct packed {
    logic [31:0] rdata;
    logic        hit;
  } cache_resp_t;

  // per-set tag entry
  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0] tag;
    logic                       valid;
    logic                       dirty;
  } tag_entry_t;

  typedef enum logic [1:0] {
    idle,
    compare,
    write_back,
    fill
  } cache_state_e;

  typedef logic [`CACHE_LINE_BITS-1:0] cache_line_t;

endpackage

// File: common/mem_bus_pkg.sv
`include "cache_defs.svh"

package mem_bus_pkg;

  // whole-line operations only
  typedef enum logic {
    mem_read,
    mem_write
  } mem_op_e;

  // line_addr is the byte address without the line offset
  typedef struct packed {
    mem_op_e                        op;
    logic [`MEM_LINE_ADDR_BITS-1:0] line_addr;
    cache_types_pkg::cache_line_t   wdata;
  } mem_req_t;

endpackage

// File: hw/cache_top.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  input  cache_types_pkg::cache_req_t   req,
  output logic                          ready,
  output logic                          resp_valid,
  output cache_types_pkg::cache_resp_t  resp
);

  logic [`CACHE_INDEX_BITS-1:0] index;
  logic                         tag_we;
  logic                         data_we;
  logic                         mem_valid;
  logic                         mem_ready;
  logic                         mem_rvalid;

  cache_types_pkg::tag_entry_t  tag_wentry;
  cache_types_pkg::tag_entry_t  tag_rentry;
  cache_types_pkg::cache_line_t data_wline;
  cache_types_pkg::cache_line_t data_rline;
  cache_types_pkg::cache_line_t mem_rline;
  mem_bus_pkg::mem_req_t        mem_req;

  cache_ctrl cache_ctrl_i (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req(req), .ready(ready),
    .resp_valid(resp_valid), .resp(resp),
    .index(index), .tag_we(tag_we), .tag_wentry(tag_wentry),
    .data_we(data_we), .data_wline(data_wline),
    .tag_rentry(tag_rentry), .data_rline(data_rline),
    .mem_valid(mem_valid), .mem_req(mem_req), .mem_ready(mem_ready),
    .mem_rvalid(mem_rvalid), .mem_rline(mem_rline)
  );

  cache_tag_store cache_tag_store_i (
    .clk(clk), .reset(reset), .index(index),
    .we(tag_we), .wentry(tag_wentry), .rentry(tag_rentry)
  );

  cache_data_store cache_data_store_i (
    .clk(clk), .reset(reset), .index(index),
    .we(data_we), .wline(data_wline), .rline(data_rline)
  );

  line_memory line_memory_i (
    .clk(clk), .reset(reset), .valid(mem_valid), .req(mem_req),
    .ready(mem_ready), .rvalid(mem_rvalid), .rline(mem_rline)
  );

endmodule

// File: hw/line_memory.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module line_memory (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          valid,
  input  mem_bus_pkg::mem_req_t         req,
  output logic                          ready,
  output logic                          rvalid,
  output cache_types_pkg::cache_line_t  rline
);

  cache_types_pkg::cache_line_t mem [`MEM_DEPTH];
  mem_bus_pkg::mem_req_t        req_q;

  logic [$clog2(`MEM_LATENCY+1)-1:0] count;
  logic                              busy;
  logic [$clog2(`MEM_DEPTH)-1:0]     line_sel;

  // higher line addresses alias onto the array
  assign line_sel = req_q.line_addr[$clog2(`MEM_DEPTH)-1:0];
  assign ready    = !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      count <= '0;
      rvalid <= 1'b0;
      for (int i = 0; i < `MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else begin
      rvalid <= 1'b0;
      if (!busy) begin
        if (valid) begin
          busy <= 1'b1;
          count <= `MEM_LATENCY;
        end
      end else if (count == 1) begin
        // end of latency, access happens here
        busy <= 1'b0;
        count <= '0;
        if (req_q.op == mem_bus_pkg::mem_write) begin
          mem[line_sel] <= req_q.wdata;
        end else begin
          rvalid <= 1'b1;
        end
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // request payload and read line
  always_ff @(posedge clk) begin
    if (valid && ready) begin
      req_q <= req;
    end
    if (busy && count == 1) begin
      rline <= mem[line_sel];
    end
  end

endmodule

// File: testbench/cache_tb.sv
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_tb;

  // 300 accesses of at most 15 cycles, reset included, with wide margin
  localparam int cycle_limit = 20000;

  logic                         clk;
  logic                         reset;
  logic                         req_valid;
  cache_types_pkg::cache_req_t  req;
  logic                         ready;
  logic                         resp_valid;
  cache_types_pkg::cache_resp_t resp;

  // reference model, word contents and per-set tag table
  logic [31:0]                ref_mem [1024];
  logic [`CACHE_TAG_BITS-1:0] ref_tag [`CACHE_NUM_SETS];
  logic                       ref_valid [`CACHE_NUM_SETS];

  logic [31:0] rand_state;
  int          cycles = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  cache_top cache_top_i (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req(req),
    .ready(ready),
    .resp_valid(resp_valid),
    .resp(resp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the cache stopped answering", cycles);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one request, compared against the reference model
  task automatic access(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                        output logic hit_seen, output logic [31:0] rdata_seen,
                        output int latency);
    logic [`CACHE_INDEX_BITS-1:0] idx;
    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic                         exp_hit;
    logic [31:0]                  exp_rdata;
    idx = addr[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];
    tag = addr[31 -: `CACHE_TAG_BITS];
    exp_hit = ref_valid[idx] && (ref_tag[idx] == tag);
    exp_rdata = ref_mem[addr[11:2]];
    latency = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req.addr <= addr;
    req.write <= write;
    req.wdata <= wdata;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end
    // taken on this edge
    @(posedge clk);
    req_valid <= 1'b0;
    do begin
      @(negedge clk);
      latency++;
      if (ready !== 1'b0) begin
        $display("error at %0t: ready got %b expected 0", $time, ready);
        error_count++;
      end
    end while (resp_valid !== 1'b1);
    hit_seen = resp.hit;
    rdata_seen = resp.rdata;
    if (resp.hit !== exp_hit) begin
      $display("error at %0t: resp.hit got %b expected %b", $time, resp.hit, exp_hit);
      error_count++;
    end
    if (!write && resp.rdata !== exp_rdata) begin
      $display("error at %0t: resp.rdata got %h expected %h", $time, resp.rdata, exp_rdata);
      error_count++;
    end
    if (exp_hit && latency != 1) begin
      $display("hit at %h answered %0d cycles after acceptance instead of 1", addr, latency);
      error_count++;
    end
    ref_valid[idx] = 1'b1;
    ref_tag[idx] = tag;
    if (write) begin
      ref_mem[addr[11:2]] = wdata;
    end
  endtask

  task automatic expect_result(input logic hit, input logic exp_hit,
                               input logic [31:0] data, input logic [31:0] exp_data);
    if (hit !== exp_hit) begin
      $display("error at %0t: resp.hit got %b expected %b", $time, hit, exp_hit);
      error_count++;
    end
    if (data !== exp_data) begin
      $display("error at %0t: resp.rdata got %h expected %h", $time, data, exp_data);
      error_count++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, error_count - errors_before);
    end
  endtask

  task automatic run_reset_read();
    logic        hit;
    logic [31:0] data;
    int          lat;
    int          errs;
    errs = error_count;
    access(32'h0000_0340, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b0, data, 32'h0);
    report_test(1, "read after reset", errs);
  endtask

  task automatic run_write_read();
    logic        hit;
    logic [31:0] data;
    int          lat;
    int          errs;
    errs = error_count;
    access(32'h0000_0120, 1'b1, 32'h1234_5678, hit, data, lat);
    if (hit !== 1'b0) begin
      $display("error at %0t: resp.hit got %b expected 0", $time, hit);
      error_count++;
    end
    access(32'h0000_0120, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b1, data, 32'h1234_5678);
    // neighbour word of the same line
    access(32'h0000_0124, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b1, data, 32'h0);
    report_test(2, "write miss then read", errs);
  endtask

  task automatic run_hit_timing();
    logic        hit;
    logic [31:0] data;
    int          lat;
    int          errs;
    errs = error_count;
    access(32'h0000_0128, 1'b1, 32'h0bad_f00d, hit, data, lat);
    if (lat != 1) begin
      $display("write hit answered after %0d cycles instead of 1", lat);
      error_count++;
    end
    access(32'h0000_0128, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b1, data, 32'h0bad_f00d);
    if (lat != 1) begin
      $display("read hit answered after %0d cycles instead of 1", lat);
      error_count++;
    end
    report_test(3, "hit timing", errs);
  endtask

  task automatic run_write_back();
    logic        hit;
    logic [31:0] data;
    int          lat;
    int          errs;
    errs = error_count;
    // same index 5, tags 2 and 7
    access(32'h0000_0250, 1'b1, 32'hcafe_0250, hit, data, lat);
    access(32'h0000_0750, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b0, data, 32'h0);
    access(32'h0000_0250, 1'b0, 32'h0, hit, data, lat);
    expect_result(hit, 1'b0, data, 32'hcafe_0250);
    report_test(4, "dirty eviction", errs);
  endtask

  task automatic run_random();
    logic        hit;
    logic [31:0] data;
    logic [31:0] addr;
    logic        write;
    int          lat;
    int          errs;
    errs = error_count;
    for (int n = 0; n < 250; n++) begin
      rand_state = xorshift32(rand_state);
      addr = {20'h0, rand_state[11:2], 2'b00};
      write = rand_state[31];
      rand_state = xorshift32(rand_state);
      access(addr, write, rand_state, hit, data, lat);
    end
    report_test(5, "random accesses", errs);
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    rand_state = 32'hd0e3_735a;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = 32'h0;
    end
    for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
      ref_tag[i] = '0;
      ref_valid[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    run_reset_read();
    run_write_read();
    run_hit_timing();
    run_write_back();
    run_random();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
